// File: sources.f
verilog/bridge_pkg.sv
verilog/read_arbiter.sv
verilog/line_writer.sv
verilog/axi_cache_bridge.sv
dv/tb_clock.sv
dv/axi_mem_model.sv
dv/tb_top.sv

// File: run.sh
#!/bin/sh
# build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top -f sources.f -o tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation returned status $status"
	exit $status
fi

exit 0

// File: dv/tb_top.sv
`timescale 1ns/10ps

module tb_top;

	localparam int          LINE_WORDS = 16;
	localparam int          SEED       = 47;
	localparam int          STALL_MAX  = 3;
	localparam logic [31:0] FILL       = 32'h5a3c_96e1;
	localparam int          ROWS       = 11;
	localparam int          WATCHDOG_NS = ROWS * 20 * 5 * 100;

	localparam int OP_IC_RD   = 0;
	localparam int OP_DC_RD   = 1;
	localparam int OP_LINE_WR = 2;
	localparam int OP_UC_RD   = 3;
	localparam int OP_UC_WR   = 4;
	localparam int OP_DUAL_RD = 5; // dcache side reads addr - 0x1000

	// operation, address, conf_sel, data seed, beats expected per port
	localparam int T_OP [ROWS] = '{OP_IC_RD, OP_LINE_WR, OP_DC_RD, OP_UC_WR, OP_UC_RD,
		OP_DUAL_RD, OP_LINE_WR, OP_IC_RD, OP_DC_RD, OP_DUAL_RD, OP_UC_RD};
	localparam logic [31:0] T_ADDR [ROWS] = '{32'h1000, 32'h2000, 32'h2000, 32'h8000,
		32'h8000, 32'h3000, 32'h3000, 32'h3000, 32'h4000, 32'h5000, 32'h9004};
	localparam logic T_CONF [ROWS] = '{0, 0, 0, 1, 1, 0, 0, 0, 0, 0, 1};
	localparam logic [7:0] T_SEED [ROWS] = '{8'h00, 8'h03, 8'h00, 8'h07, 8'h00,
		8'h00, 8'h09, 8'h00, 8'h00, 8'h00, 8'h00};
	localparam int T_BEATS [ROWS] = '{16, 0, 16, 0, 1, 16, 0, 16, 16, 16, 1};

	logic clk;
	logic rst;
	logic icache_rd_req;
	logic [31:0] icache_rd_addr;
	logic icache_rd_rdy;
	logic icache_ret_valid;
	logic icache_ret_last;
	logic dcache_rd_req;
	logic [31:0] dcache_rd_addr;
	logic dcache_rd_rdy;
	logic dcache_ret_valid;
	logic dcache_ret_last;
	logic dcache_wr_req;
	logic [31:0] dcache_wr_addr;
	logic [LINE_WORDS*32-1:0] dcache_wr_line;
	logic dcache_wr_rdy;
	logic [31:0] uncache_wr_data;
	logic conf_sel;
	logic [31:0] ret_data;
	logic [3:0] arid;
	logic [31:0] araddr;
	logic [3:0] arlen;
	logic [2:0] arsize;
	logic [1:0] arburst;
	logic arvalid;
	logic arready;
	logic [3:0] rid;
	logic [31:0] rdata;
	logic rlast;
	logic rvalid;
	logic rready;
	logic [3:0] awid;
	logic [31:0] awaddr;
	logic [3:0] awlen;
	logic [2:0] awsize;
	logic [1:0] awburst;
	logic awvalid;
	logic awready;
	logic [3:0] wid;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wlast;
	logic wvalid;
	logic wready;
	logic bvalid;
	logic bready;
	logic proto_err;

	logic [31:0] ref_mem [logic [31:0]]; // what memory should hold

	tb_clock #(.PERIOD_NS(100), .RESET_CYCLES(3)) clk_i (.clk(clk), .rst(rst));

	axi_cache_bridge #(.LINE_WORDS(LINE_WORDS)) dut_i (.*);

	axi_mem_model #(
		.LINE_WORDS(LINE_WORDS),
		.STALL_MAX(STALL_MAX),
		.FILL(FILL)
	) mem_i (.*);

	function automatic logic [31:0] ref_word(input logic [31:0] a);
		return ref_mem.exists(a) ? ref_mem[a] : (a ^ FILL);
	endfunction

	function automatic logic [31:0] line_word(input logic [7:0] seed, input int i);
		return {seed, 8'(i), 8'(seed ^ 8'(i * 3)), 8'h5c};
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		if (got !== exp)
		begin
			$display("Error: %0t ns: %s, got %h expected %h", $time, what, got, exp);
			$display("Simulation failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// returns on the falling edge after the request was taken
	task automatic wait_accept(input int port);
		logic rdy;
		bit done;
		done = 1'b0;
		while (!done)
		begin
			#1;
			case (port)
				0: rdy = icache_rd_rdy;
				1: rdy = dcache_rd_rdy;
				default: rdy = dcache_wr_rdy;
			endcase
			if (rdy)
				done = 1'b1;
			@(negedge clk);
		end
	endtask

	task automatic collect_beats(input bit to_ic, input int n, input logic [31:0] addr,
		input bit incr);
		int i;
		logic [31:0] exp;
		i = 0;
		while (i < n)
		begin
			@(negedge clk);
			if (icache_ret_valid || dcache_ret_valid)
			begin
				check_value(32'(to_ic ? dcache_ret_valid : icache_ret_valid), 32'd0,
					"beat reached the other cache");
				exp = ref_word(addr + (incr ? 32'(4 * i) : 32'd0));
				check_value(ret_data, exp, "return data");
				check_value(32'(to_ic ? icache_ret_last : dcache_ret_last), 32'(i == n - 1),
					"last flag");
				i++;
			end
		end
	endtask

	task automatic write_line(input logic [31:0] a, input logic conf, input logic [7:0] seed);
		if (conf)
		begin
			uncache_wr_data = line_word(seed, 0);
			ref_mem[a] = uncache_wr_data;
		end
		else
		begin
			for (int i = 0; i < LINE_WORDS; i++)
			begin
				dcache_wr_line[i*32 +: 32] = line_word(seed, i);
				ref_mem[a + 32'(4 * i)] = line_word(seed, i);
			end
		end
		conf_sel = conf;
		dcache_wr_addr = a;
		dcache_wr_req = 1'b1;
		wait_accept(2);
		dcache_wr_req = 1'b0;
		conf_sel = 1'b0;
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns with rows still running", WATCHDOG_NS);
		$display("Simulation failed");
		$fatal(1, "timeout");
	end

	always @(posedge clk)
	begin
		if (proto_err)
		begin
			$display("the memory model saw an AXI protocol violation");
			$display("Simulation failed");
			$fatal(1, "protocol violation");
		end
	end

	initial
	begin
		void'($urandom(SEED));
		icache_rd_req = 1'b0;
		icache_rd_addr = '0;
		dcache_rd_req = 1'b0;
		dcache_rd_addr = '0;
		dcache_wr_req = 1'b0;
		dcache_wr_addr = '0;
		dcache_wr_line = '0;
		uncache_wr_data = '0;
		conf_sel = 1'b0;
		@(posedge rst);
		@(negedge clk);
		for (int r = 0; r < ROWS; r++)
		begin
			case (T_OP[r])
				OP_IC_RD:
				begin
					icache_rd_addr = T_ADDR[r];
					icache_rd_req = 1'b1;
					wait_accept(0);
					icache_rd_req = 1'b0;
					collect_beats(1'b1, T_BEATS[r], T_ADDR[r], 1'b1);
				end
				OP_DC_RD, OP_UC_RD:
				begin
					conf_sel = T_CONF[r];
					dcache_rd_addr = T_ADDR[r];
					dcache_rd_req = 1'b1;
					wait_accept(1);
					dcache_rd_req = 1'b0;
					conf_sel = 1'b0;
					collect_beats(1'b0, T_BEATS[r], T_ADDR[r], !T_CONF[r]);
				end
				OP_DUAL_RD:
				begin
					icache_rd_addr = T_ADDR[r];
					dcache_rd_addr = T_ADDR[r] - 32'h1000;
					icache_rd_req = 1'b1;
					dcache_rd_req = 1'b1; // same cycle, icache wins
					wait_accept(0);
					icache_rd_req = 1'b0;
					collect_beats(1'b1, T_BEATS[r], T_ADDR[r], 1'b1);
					wait_accept(1);
					dcache_rd_req = 1'b0;
					collect_beats(1'b0, T_BEATS[r], T_ADDR[r] - 32'h1000, 1'b1);
				end
				default:
					write_line(T_ADDR[r], T_CONF[r], T_SEED[r]);
			endcase
		end
		repeat (4) @(negedge clk);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// File: dv/axi_mem_model.sv
`timescale 1ns/10ps

module axi_mem_model #(
	parameter int          LINE_WORDS = 16,
	parameter int          STALL_MAX  = 3,
	parameter logic [31:0] FILL       = 32'h0
) (
	input  logic        clk,
	input  logic        rst,
	input  logic [3:0]  arid,
	input  logic [31:0] araddr,
	input  logic [3:0]  arlen,
	input  logic [2:0]  arsize,
	input  logic [1:0]  arburst,
	input  logic        arvalid,
	output logic        arready,
	output logic [3:0]  rid,
	output logic [31:0] rdata,
	output logic        rlast,
	output logic        rvalid,
	input  logic        rready,
	input  logic [3:0]  awid,
	input  logic [31:0] awaddr,
	input  logic [3:0]  awlen,
	input  logic [2:0]  awsize,
	input  logic [1:0]  awburst,
	input  logic        awvalid,
	output logic        awready,
	input  logic [3:0]  wid,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        wlast,
	input  logic        wvalid,
	output logic        wready,
	output logic        bvalid,
	input  logic        bready,
	output logic        proto_err
);

	logic [31:0] mem [logic [31:0]]; // sparse, keyed by byte address
	logic        rd_err = 1'b0;
	logic        wr_err = 1'b0;
	logic        rd_busy;
	int          ar_wait;
	int          r_wait;
	logic [3:0]  rbeat;
	logic [3:0]  ar_id_q;
	logic [31:0] ar_addr_q;
	logic [3:0]  ar_len_q;
	logic        ar_incr_q;
	int          wr_ph; // 0 address, 1 data, 2 response
	int          aw_wait;
	int          w_wait;
	logic [3:0]  wbeat;
	logic [31:0] aw_addr_q;
	logic [3:0]  aw_len_q;
	logic        aw_incr_q;

	assign proto_err = rd_err || wr_err;

	function automatic logic [31:0] mem_word(input logic [31:0] a);
		return mem.exists(a) ? mem[a] : (a ^ FILL);
	endfunction

	// full line as INCR or a single FIXED word
	function automatic bit shape_ok(input logic [3:0] len, input logic [1:0] burst,
		input logic [2:0] size);
		if (size != bridge_pkg::SIZE_WORD)
			return 1'b0;
		if (burst == bridge_pkg::BURST_INCR)
			return len == 4'(LINE_WORDS - 1);
		return (burst == bridge_pkg::BURST_FIXED) && (len == 4'd0);
	endfunction

	function automatic int stall();
		return int'($urandom % (STALL_MAX + 1));
	endfunction

	always @(posedge clk)
	begin
		if (!rst)
		begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
			rlast   <= 1'b0;
			rd_busy <= 1'b0;
			ar_wait <= 0;
			r_wait  <= 0;
			rbeat   <= '0;
		end
		else if (!rd_busy)
		begin
			if (arvalid && arready)
			begin
				if (!shape_ok(arlen, arburst, arsize))
				begin
					$display("memory model: bad read burst, len %0d burst %0d size %0d",
						arlen, arburst, arsize);
					rd_err <= 1'b1;
				end
				ar_id_q   <= arid;
				ar_addr_q <= araddr;
				ar_len_q  <= arlen;
				ar_incr_q <= (arburst == bridge_pkg::BURST_INCR);
				rd_busy   <= 1'b1;
				arready   <= 1'b0;
				rbeat     <= '0;
				r_wait    <= stall();
			end
			else if (ar_wait != 0)
			begin
				arready <= 1'b0;
				ar_wait <= ar_wait - 1;
			end
			else
				arready <= 1'b1;
		end
		else if (rvalid && rready)
		begin
			rvalid <= 1'b0;
			rlast  <= 1'b0;
			rbeat  <= rbeat + 4'd1;
			r_wait <= stall();
			if (rlast)
			begin
				rd_busy <= 1'b0;
				ar_wait <= stall();
			end
		end
		else if (r_wait != 0)
			r_wait <= r_wait - 1;
		else
		begin
			rvalid <= 1'b1;
			rid    <= ar_id_q;
			rdata  <= mem_word(ar_addr_q + (ar_incr_q ? 32'({rbeat, 2'b00}) : 32'd0));
			rlast  <= (rbeat == ar_len_q);
		end
	end

	always @(posedge clk)
	begin
		if (!rst)
		begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			wr_ph   <= 0;
			aw_wait <= 0;
			w_wait  <= 0;
			wbeat   <= '0;
		end
		else if (wr_ph == 0)
		begin
			if (awvalid && awready)
			begin
				if (!shape_ok(awlen, awburst, awsize) || awid != wid)
				begin
					$display("memory model: bad write burst, len %0d burst %0d size %0d",
						awlen, awburst, awsize);
					wr_err <= 1'b1;
				end
				aw_addr_q <= awaddr;
				aw_len_q  <= awlen;
				aw_incr_q <= (awburst == bridge_pkg::BURST_INCR);
				awready   <= 1'b0;
				wbeat     <= '0;
				w_wait    <= stall();
				wr_ph     <= 1;
			end
			else if (aw_wait != 0)
			begin
				awready <= 1'b0;
				aw_wait <= aw_wait - 1;
			end
			else
				awready <= 1'b1;
		end
		else if (wr_ph == 1)
		begin
			if (wvalid && wready)
			begin
				if (wstrb != 4'hf || wlast != (wbeat == aw_len_q))
				begin
					$display("memory model: write beat %0d has wrong strobe or wlast", wbeat);
					wr_err <= 1'b1;
				end
				mem[aw_addr_q + (aw_incr_q ? 32'({wbeat, 2'b00}) : 32'd0)] = wdata;
				wbeat  <= wbeat + 4'd1;
				wready <= 1'b0;
				w_wait <= stall();
				if (wlast)
					wr_ph <= 2;
			end
			else if (w_wait != 0)
				w_wait <= w_wait - 1;
			else
				wready <= 1'b1;
		end
		else if (bvalid && bready)
		begin
			bvalid  <= 1'b0;
			wr_ph   <= 0;
			aw_wait <= stall();
		end
		else
			bvalid <= 1'b1;
	end

endmodule

// File: dv/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// active low reset released on a falling edge
	initial
	begin
		rst = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
	end

endmodule

// File: verilog/axi_cache_bridge.sv
`timescale 1ns/10ps

module axi_cache_bridge #(
	parameter int LINE_WORDS = 16
) (
	input  logic                                      clk,
	input  logic                                      rst,

	// icache read
	input  logic                                      icache_rd_req,
	input  logic [bridge_pkg::ADDR_W-1:0]             icache_rd_addr,
	output logic                                      icache_rd_rdy,
	output logic                                      icache_ret_valid,
	output logic                                      icache_ret_last,

	// dcache read and write
	input  logic                                      dcache_rd_req,
	input  logic [bridge_pkg::ADDR_W-1:0]             dcache_rd_addr,
	output logic                                      dcache_rd_rdy,
	output logic                                      dcache_ret_valid,
	output logic                                      dcache_ret_last,
	input  logic                                      dcache_wr_req,
	input  logic [bridge_pkg::ADDR_W-1:0]             dcache_wr_addr,
	input  logic [LINE_WORDS*bridge_pkg::DATA_W-1:0]  dcache_wr_line,
	output logic                                      dcache_wr_rdy,
	input  logic [bridge_pkg::DATA_W-1:0]             uncache_wr_data,
	input  logic                                      conf_sel,
	output logic [bridge_pkg::DATA_W-1:0]             ret_data,

	// axi read
	output logic [bridge_pkg::ID_W-1:0]               arid,
	output logic [bridge_pkg::ADDR_W-1:0]             araddr,
	output logic [3:0]                                arlen,
	output logic [2:0]                                arsize,
	output logic [1:0]                                arburst,
	output logic                                      arvalid,
	input  logic                                      arready,
	input  logic [bridge_pkg::ID_W-1:0]               rid,
	input  logic [bridge_pkg::DATA_W-1:0]             rdata,
	input  logic                                      rlast,
	input  logic                                      rvalid,
	output logic                                      rready,

	// axi write
	output logic [bridge_pkg::ID_W-1:0]               awid,
	output logic [bridge_pkg::ADDR_W-1:0]             awaddr,
	output logic [3:0]                                awlen,
	output logic [2:0]                                awsize,
	output logic [1:0]                                awburst,
	output logic                                      awvalid,
	input  logic                                      awready,
	output logic [bridge_pkg::ID_W-1:0]               wid,
	output logic [bridge_pkg::DATA_W-1:0]             wdata,
	output logic [bridge_pkg::DATA_W/8-1:0]           wstrb,
	output logic                                      wlast,
	output logic                                      wvalid,
	input  logic                                      wready,
	input  logic                                      bvalid,
	output logic                                      bready
);

	logic                          wr_pending;
	logic [bridge_pkg::ADDR_W-1:0] wr_addr;

	// never back-pressure the slave
	assign rready = 1'b1;
	assign bready = 1'b1;

	read_arbiter #(
		.LINE_WORDS(LINE_WORDS)
	) rd_arb_i (
		.clk(clk), .rst(rst),
		.icache_rd_req(icache_rd_req), .icache_rd_addr(icache_rd_addr),
		.icache_rd_rdy(icache_rd_rdy),
		.dcache_rd_req(dcache_rd_req), .dcache_rd_addr(dcache_rd_addr),
		.dcache_rd_rdy(dcache_rd_rdy), .conf_sel(conf_sel),
		.arid(arid), .araddr(araddr), .arlen(arlen), .arsize(arsize),
		.arburst(arburst), .arvalid(arvalid), .arready(arready),
		.rid(rid), .rdata(rdata), .rlast(rlast), .rvalid(rvalid),
		.wr_pending(wr_pending), .wr_addr(wr_addr),
		.icache_ret_valid(icache_ret_valid), .icache_ret_last(icache_ret_last),
		.dcache_ret_valid(dcache_ret_valid), .dcache_ret_last(dcache_ret_last),
		.ret_data(ret_data)
	);

	line_writer #(
		.LINE_WORDS(LINE_WORDS)
	) wr_i (
		.clk(clk), .rst(rst),
		.dcache_wr_req(dcache_wr_req), .dcache_wr_addr(dcache_wr_addr),
		.dcache_wr_line(dcache_wr_line), .dcache_wr_rdy(dcache_wr_rdy),
		.uncache_wr_data(uncache_wr_data), .conf_sel(conf_sel),
		.wr_pending(wr_pending), .wr_addr(wr_addr),
		.awid(awid), .awaddr(awaddr), .awlen(awlen), .awsize(awsize),
		.awburst(awburst), .awvalid(awvalid), .awready(awready),
		.wid(wid), .wdata(wdata), .wstrb(wstrb), .wlast(wlast),
		.wvalid(wvalid), .wready(wready),
		.bvalid(bvalid)
	);

endmodule

// File: verilog/line_writer.sv
`timescale 1ns/10ps

module line_writer #(
	parameter int LINE_WORDS = 16
) (
	input  logic                                      clk,
	input  logic                                      rst,

	input  logic                                      dcache_wr_req,
	input  logic [bridge_pkg::ADDR_W-1:0]             dcache_wr_addr,
	input  logic [LINE_WORDS*bridge_pkg::DATA_W-1:0]  dcache_wr_line,
	output logic                                      dcache_wr_rdy,
	input  logic [bridge_pkg::DATA_W-1:0]             uncache_wr_data,
	input  logic                                      conf_sel,

	output logic                                      wr_pending,
	output logic [bridge_pkg::ADDR_W-1:0]             wr_addr,

	output logic [bridge_pkg::ID_W-1:0]               awid,
	output logic [bridge_pkg::ADDR_W-1:0]             awaddr,
	output logic [3:0]                                awlen,
	output logic [2:0]                                awsize,
	output logic [1:0]                                awburst,
	output logic                                      awvalid,
	input  logic                                      awready,

	output logic [bridge_pkg::ID_W-1:0]               wid,
	output logic [bridge_pkg::DATA_W-1:0]             wdata,
	output logic [bridge_pkg::DATA_W/8-1:0]           wstrb,
	output logic                                      wlast,
	output logic                                      wvalid,
	input  logic                                      wready,

	input  logic                                      bvalid
);

	localparam int         CNT_W    = (LINE_WORDS > 1) ? $clog2(LINE_WORDS) : 1;
	localparam logic [3:0] LINE_LEN = 4'(LINE_WORDS - 1);

	bridge_pkg::wr_state_t state;
	bridge_pkg::wr_state_t state_nxt;
	logic [LINE_WORDS*bridge_pkg::DATA_W-1:0] line_buf;
	logic [bridge_pkg::DATA_W-1:0] uc_word;
	logic [CNT_W-1:0] beat_cnt;
	logic uncached;
	logic wr_take;
	logic beat_go;
	logic last_beat;

	assign dcache_wr_rdy = (state == bridge_pkg::WR_IDLE) && awready;
	assign wr_take       = dcache_wr_req && dcache_wr_rdy;
	assign beat_go       = wvalid && wready;

	// final beat of the burst
	assign last_beat = uncached || (beat_cnt == CNT_W'(LINE_WORDS - 1));

	always_ff @(posedge clk)
	begin
		if (!rst)
			state <= bridge_pkg::WR_IDLE;
		else
			state <= state_nxt;
	end

	always_comb
	begin
		state_nxt = state;
		case (state)
			bridge_pkg::WR_IDLE:
				if (wr_take)
					state_nxt = bridge_pkg::WR_ADDR;
			bridge_pkg::WR_ADDR:
				if (awready)
					state_nxt = bridge_pkg::WR_DATA;
			bridge_pkg::WR_DATA:
				if (beat_go && last_beat)
					state_nxt = bridge_pkg::WR_RESP;
			bridge_pkg::WR_RESP:
				if (bvalid) // bready tied high
					state_nxt = bridge_pkg::WR_IDLE;
			default:
				state_nxt = bridge_pkg::WR_IDLE;
		endcase
	end

	// kind of write and beat counter
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			uncached <= 1'b0;
			beat_cnt <= '0;
		end
		else if (wr_take)
		begin
			uncached <= conf_sel;
			beat_cnt <= '0;
		end
		else if (beat_go)
			beat_cnt <= beat_cnt + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (wr_take)
		begin
			wr_addr  <= dcache_wr_addr;
			line_buf <= dcache_wr_line;
			uc_word  <= uncache_wr_data;
		end
		else if (beat_go)
			line_buf <= line_buf >> bridge_pkg::DATA_W; // next word into the low bits
	end

	// held from acceptance until the response is back
	assign wr_pending = (state != bridge_pkg::WR_IDLE);

	assign awid    = bridge_pkg::ID_DCACHE;
	assign awaddr  = wr_addr;
	assign awlen   = uncached ? 4'd0 : LINE_LEN;
	assign awsize  = bridge_pkg::SIZE_WORD;
	assign awburst = uncached ? bridge_pkg::BURST_FIXED : bridge_pkg::BURST_INCR;
	assign awvalid = (state == bridge_pkg::WR_ADDR);

	assign wid    = bridge_pkg::ID_DCACHE;
	assign wdata  = uncached ? uc_word : line_buf[bridge_pkg::DATA_W-1:0];
	assign wstrb  = '1; // always full words
	assign wvalid = (state == bridge_pkg::WR_DATA);
	assign wlast  = wvalid && last_beat;

	b_after_last: assert property (@(posedge clk) disable iff (!rst)
		bvalid |-> state == bridge_pkg::WR_RESP)
		else $error("write response arrived before the last data beat");

endmodule

// File: verilog/read_arbiter.sv
`timescale 1ns/10ps

module read_arbiter #(
	parameter int LINE_WORDS = 16
) (
	input  logic                            clk,
	input  logic                            rst,

	input  logic                            icache_rd_req,
	input  logic [bridge_pkg::ADDR_W-1:0]   icache_rd_addr,
	output logic                            icache_rd_rdy,
	input  logic                            dcache_rd_req,
	input  logic [bridge_pkg::ADDR_W-1:0]   dcache_rd_addr,
	output logic                            dcache_rd_rdy,
	input  logic                            conf_sel,

	output logic [bridge_pkg::ID_W-1:0]     arid,
	output logic [bridge_pkg::ADDR_W-1:0]   araddr,
	output logic [3:0]                      arlen,
	output logic [2:0]                      arsize,
	output logic [1:0]                      arburst,
	output logic                            arvalid,
	input  logic                            arready,

	input  logic [bridge_pkg::ID_W-1:0]     rid,
	input  logic [bridge_pkg::DATA_W-1:0]   rdata,
	input  logic                            rlast,
	input  logic                            rvalid,

	input  logic                            wr_pending,
	input  logic [bridge_pkg::ADDR_W-1:0]   wr_addr,

	output logic                            icache_ret_valid,
	output logic                            icache_ret_last,
	output logic                            dcache_ret_valid,
	output logic                            dcache_ret_last,
	output logic [bridge_pkg::DATA_W-1:0]   ret_data
);

	localparam logic [3:0] LINE_LEN = 4'(LINE_WORDS - 1);

	bridge_pkg::rd_state_t state;
	bridge_pkg::rd_state_t state_nxt;
	logic ic_hazard;
	logic dc_hazard;
	logic ic_take;
	logic dc_take;
	logic beat;

	// a read may not overtake a pending write to the same address
	assign ic_hazard = wr_pending && (icache_rd_addr == wr_addr);
	assign dc_hazard = wr_pending && (dcache_rd_addr == wr_addr);

	// icache has fixed priority
	assign icache_rd_rdy = (state == bridge_pkg::RD_IDLE) && arready && !ic_hazard;
	assign dcache_rd_rdy = (state == bridge_pkg::RD_IDLE) && arready && !icache_rd_req
		&& !dc_hazard;

	assign ic_take = icache_rd_req && icache_rd_rdy;
	assign dc_take = dcache_rd_req && dcache_rd_rdy;

	always_ff @(posedge clk)
	begin
		if (!rst)
			state <= bridge_pkg::RD_IDLE;
		else
			state <= state_nxt;
	end

	always_comb
	begin
		state_nxt = state;
		case (state)
			bridge_pkg::RD_IDLE:
				if (ic_take || dc_take)
					state_nxt = bridge_pkg::RD_ADDR;
			bridge_pkg::RD_ADDR:
				if (arready)
					state_nxt = bridge_pkg::RD_DATA;
			bridge_pkg::RD_DATA:
				if (rvalid && rlast)
					state_nxt = bridge_pkg::RD_IDLE;
			default:
				state_nxt = bridge_pkg::RD_IDLE;
		endcase
	end

	// request shape captured at acceptance
	always_ff @(posedge clk)
	begin
		if (ic_take)
		begin
			arid    <= bridge_pkg::ID_ICACHE;
			araddr  <= icache_rd_addr;
			arlen   <= LINE_LEN;
			arburst <= bridge_pkg::BURST_INCR;
		end
		else if (dc_take)
		begin
			arid    <= bridge_pkg::ID_DCACHE;
			araddr  <= dcache_rd_addr;
			arlen   <= conf_sel ? 4'd0 : LINE_LEN; // config space is one word
			arburst <= conf_sel ? bridge_pkg::BURST_FIXED : bridge_pkg::BURST_INCR;
		end
	end

	assign arsize  = bridge_pkg::SIZE_WORD;
	assign arvalid = (state == bridge_pkg::RD_ADDR);

	// steer each beat by rid bit 0
	assign beat = (state == bridge_pkg::RD_DATA) && rvalid;

	assign icache_ret_valid = beat && !rid[0];
	assign icache_ret_last  = beat && !rid[0] && rlast;
	assign dcache_ret_valid = beat && rid[0];
	assign dcache_ret_last  = beat && rid[0] && rlast;
	assign ret_data         = rdata;

	r_in_burst: assert property (@(posedge clk) disable iff (!rst)
		rvalid |-> state == bridge_pkg::RD_DATA)
		else $error("read data arrived with no burst in flight");

	rid_match: assert property (@(posedge clk) disable iff (!rst)
		rvalid |-> rid == arid)
		else $error("read beat carries an id that was not requested");

endmodule

// File: verilog/bridge_pkg.sv
package bridge_pkg;

	// bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int ID_W   = 4;

	// bit 0 of rid picks the receiving cache
	localparam logic [ID_W-1:0] ID_ICACHE = 4'd0;
	localparam logic [ID_W-1:0] ID_DCACHE = 4'd1;

	// axi burst types
	localparam logic [1:0] BURST_FIXED = 2'd0;
	localparam logic [1:0] BURST_INCR  = 2'd1;

	localparam logic [2:0] SIZE_WORD = 3'd2; // 4 byte beats

	// read channel fsm
	typedef enum logic [1:0] {
		RD_IDLE = 2'd0,
		RD_ADDR = 2'd1,
		RD_DATA = 2'd2
	} rd_state_t;

	// write channel fsm
	typedef enum logic [1:0] {
		WR_IDLE = 2'd0,
		WR_ADDR = 2'd1,
		WR_DATA = 2'd2,
		WR_RESP = 2'd3
	} wr_state_t;

endpackage
